/* Makefile */
# Verilator build and run of the ALU pipe testbench

VERILATOR ?= verilator
TOP       ?= tb_alu_core
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/alu_core_top.sv */
`default_nettype none

module alu_core_top import rv_core_pkg::*; #(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RETIRE_CREDITS = 2
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  in_valid,
    input  wire word_t in_instr,
    output logic       in_credit,
    output logic       out_valid,
    output reg_idx_t   out_rd,
    output word_t      out_value,
    output logic       out_illegal,
    input  wire logic  out_credit
);

    logic     dec_valid;                         // Queue head to decode
    word_t    dec_instr;
    logic     dec_stall;
    logic     wb_en;                             // ALU writeback into reg file
    reg_idx_t wb_rd;
    word_t    wb_value;

    decoded_op_if dec_op ();
    retire_if     ret ();

    instr_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_instr_queue (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_instr(in_instr), .in_credit(in_credit),
        .dec_valid(dec_valid), .dec_instr(dec_instr), .dec_stall(dec_stall)
    );

    id_stage u_id_stage (
        .clk(clk), .reset(reset),
        .dec_valid(dec_valid), .dec_instr(dec_instr), .dec_stall(dec_stall),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_value(wb_value),
        .out_op(dec_op)
    );

    alu_stage u_alu_stage (
        .clk(clk), .reset(reset), .in_op(dec_op),
        .wb_en(wb_en), .wb_rd(wb_rd), .wb_value(wb_value),
        .out_ret(ret)
    );

    retire_port #(.RETIRE_CREDITS(RETIRE_CREDITS)) u_retire_port (
        .clk(clk), .reset(reset), .in_ret(ret),
        .out_valid(out_valid), .out_rd(out_rd), .out_value(out_value),
        .out_illegal(out_illegal), .out_credit(out_credit)
    );

endmodule

`default_nettype wire

/* source/alu_stage.sv */
`default_nettype none

module alu_stage import rv_core_pkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    decoded_op_if.sink in_op,
    output logic      wb_en,
    output reg_idx_t  wb_rd,
    output word_t     wb_value,
    retire_if.source  out_ret
);

    logic  accept;
    logic  last_wr;                              // Retire record wrote a register
    logic  fwd_a;
    logic  fwd_b;
    word_t op_a;
    word_t op_b;
    word_t result;

    assign in_op.stall = out_ret.valid && out_ret.stall;
    assign accept      = in_op.valid && !in_op.stall;

    // Forward from the previous result by register number
    assign fwd_a = last_wr && (in_op.rs1 == out_ret.rd);
    assign fwd_b = last_wr && (in_op.rs2 == out_ret.rd);
    assign op_a  = fwd_a ? out_ret.value : in_op.a;
    assign op_b  = fwd_b ? out_ret.value : in_op.b;

    always_comb begin
        case (in_op.alu_op)
            alu_add:    result = op_a + op_b;
            alu_sub:    result = op_a - op_b;
            alu_sll:    result = op_a << op_b[4:0];
            alu_slt:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   result = {31'b0, op_a < op_b};
            alu_xor:    result = op_a ^ op_b;
            alu_srl:    result = op_a >> op_b[4:0];
            alu_sra:    result = word_t'($signed(op_a) >>> op_b[4:0]);
            alu_or:     result = op_a | op_b;
            alu_and:    result = op_a & op_b;
            alu_pass_b: result = op_b;           // LUI
            default:    result = '0;
        endcase
        if (in_op.illegal) result = '0;          // Illegal retires as zero
    end

    // Writeback on the edge the record registers
    assign wb_en    = accept && in_op.writes_rd;
    assign wb_rd    = in_op.rd;
    assign wb_value = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_ret.valid <= 1'b0;
            last_wr       <= 1'b0;
        end else if (!in_op.stall) begin
            out_ret.valid <= in_op.valid;
            if (in_op.valid) last_wr <= in_op.writes_rd;
        end
    end

    // Payload holds the last accepted item, also the forward source
    always_ff @(posedge clk) begin
        if (accept) begin
            out_ret.rd      <= in_op.rd;
            out_ret.value   <= result;
            out_ret.illegal <= in_op.illegal;
        end
    end

endmodule

`default_nettype wire

/* source/id_stage.sv */
`default_nettype none

module id_stage import rv_core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     dec_valid,
    input  wire word_t    dec_instr,
    output logic          dec_stall,
    input  wire logic     wb_en,
    input  wire reg_idx_t wb_rd,
    input  wire word_t    wb_value,
    decoded_op_if.source  out_op
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       f7_5;                            // funct7[5], sub and arithmetic shift
    alu_op_e    d_alu_op;
    reg_idx_t   d_rd;
    reg_idx_t   d_rs1;
    reg_idx_t   d_rs2;
    word_t      d_b;
    logic       d_illegal;
    word_t      rs1_data;
    word_t      rs2_data;
    logic       load;

    reg_file u_reg_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (d_rs1),
        .rs2      (d_rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .w_en     (wb_en),
        .w_sel    (wb_rd),
        .w_data   (wb_value)
    );

    //////////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////////

    always_comb begin
        opcode    = get_opcode(dec_instr);
        funct3    = get_funct3(dec_instr);
        f7_5      = dec_instr[30];
        d_rd      = get_rd(dec_instr);
        d_rs1     = '0;                          // Unused operands read x0
        d_rs2     = '0;
        d_alu_op  = alu_add;
        d_b       = '0;
        d_illegal = 1'b0;

        case (opcode)
            op_reg: begin
                d_rs1 = get_rs1(dec_instr);
                d_rs2 = get_rs2(dec_instr);
                d_b   = rs2_data;
                // funct7[5] only counts for add/sub and srl/sra
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    d_alu_op = alu_op_e'({f7_5, funct3});
                end else begin
                    d_alu_op = alu_op_e'({1'b0, funct3});
                end
            end
            op_imm: begin
                d_rs1 = get_rs1(dec_instr);
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    d_b      = {27'b0, dec_instr[24:20]};      // Shift amount only
                    d_alu_op = alu_op_e'({f7_5 && funct3[2], funct3});
                end else begin
                    d_b      = imm_i(dec_instr);
                    d_alu_op = alu_op_e'({1'b0, funct3});      // No subi
                end
            end
            op_lui: begin
                d_b      = imm_u(dec_instr);
                d_alu_op = alu_pass_b;
            end
            default: begin
                d_illegal = 1'b1;                // Retires flagged, no write
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////////
    // Register toward the ALU
    //////////////////////////////////////////////////////////////////////////

    assign dec_stall = out_op.valid && out_op.stall;    // Hold while ALU is full
    assign load      = dec_valid && !dec_stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_op.valid <= 1'b0;
        end else if (!dec_stall) begin
            out_op.valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out_op.alu_op    <= d_alu_op;
            out_op.rd        <= d_rd;
            out_op.rs1       <= d_rs1;
            out_op.rs2       <= d_rs2;
            out_op.a         <= rs1_data;
            out_op.b         <= d_b;
            out_op.writes_rd <= !d_illegal && (d_rd != '0);
            out_op.illegal   <= d_illegal;
        end
    end

endmodule

`default_nettype wire

/* source/instr_queue.sv */
`default_nettype none

module instr_queue import rv_core_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  in_valid,
    input  wire word_t in_instr,
    output logic       in_credit,
    output logic       dec_valid,
    output word_t      dec_instr,
    input  wire logic  dec_stall
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    word_t            mem [QUEUE_DEPTH];         // Instruction storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                     // Occupancy
    logic             push;
    logic             pop;

    assign push      = in_valid;                 // Producer only sends against a credit
    assign dec_valid = (count != '0);
    assign dec_instr = mem[rd_ptr];              // Head of queue
    assign pop       = dec_valid && !dec_stall;

    // Next pointer with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;                    // One credit back per pop
            if (push) wr_ptr <= ptr_next(wr_ptr);
            if (pop)  rd_ptr <= ptr_next(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;         // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_instr;
    end

    // Producer sent without holding a credit
    a_no_overrun: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (count != CNT_W'(QUEUE_DEPTH)));

endmodule

`default_nettype wire

/* source/pipe_if.sv */
`default_nettype none

// Decode to execute link
interface decoded_op_if import rv_core_pkg::*; ();
    logic     valid;
    logic     stall;                             // Back from the receiver
    alu_op_e  alu_op;
    reg_idx_t rd;
    reg_idx_t rs1;                               // Zero when the operand is not a register
    reg_idx_t rs2;
    word_t    a;
    word_t    b;                                 // Register value or immediate
    logic     writes_rd;
    logic     illegal;

    modport source (output valid, alu_op, rd, rs1, rs2, a, b, writes_rd, illegal,
                    input stall);
    modport sink   (input valid, alu_op, rd, rs1, rs2, a, b, writes_rd, illegal,
                    output stall);
endinterface

// Execute to retire link
interface retire_if import rv_core_pkg::*; ();
    logic     valid;
    logic     stall;
    reg_idx_t rd;
    word_t    value;
    logic     illegal;

    modport source (output valid, rd, value, illegal, input stall);
    modport sink   (input valid, rd, value, illegal, output stall);
endinterface

`default_nettype wire

/* source/reg_file.sv */
`default_nettype none

module reg_file import rv_core_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire reg_idx_t rs1,
    input  wire reg_idx_t rs2,
    output word_t         rs1_data,
    output word_t         rs2_data,
    input  wire logic     w_en,
    input  wire reg_idx_t w_sel,
    input  wire word_t    w_data
);

    word_t regs [1:31];                          // x0 has no storage

    // Read with write-through, x0 is always zero
    function automatic word_t read_port(reg_idx_t sel);
        if (sel == '0) begin
            return '0;
        end
        if (w_en && (w_sel == sel)) begin
            return w_data;                       // Same cycle write wins
        end
        return regs[sel];
    endfunction

    assign rs1_data = read_port(rs1);
    assign rs2_data = read_port(rs2);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && (w_sel != '0)) begin
            regs[w_sel] <= w_data;
        end
    end

    // Decode must have dropped rd = x0 before writeback
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        !(w_en && (w_sel == '0)));

endmodule

`default_nettype wire

/* source/retire_port.sv */
`default_nettype none

module retire_port import rv_core_pkg::*; #(
    parameter int RETIRE_CREDITS = 2
) (
    input  wire logic clk,
    input  wire logic reset,
    retire_if.sink    in_ret,
    output logic      out_valid,
    output reg_idx_t  out_rd,
    output word_t     out_value,
    output logic      out_illegal,
    input  wire logic out_credit
);

    localparam int CRED_W = $clog2(RETIRE_CREDITS + 1) + 1;   // Spare bit shows overflow

    logic [CRED_W-1:0] credits;
    logic              have_credit;
    logic              pend_valid;               // One-entry holding record
    reg_idx_t          pend_rd;
    word_t             pend_value;
    logic              pend_illegal;
    logic              send_pend;
    logic              send_in;
    logic              accept;
    logic              spend;

    assign have_credit  = (credits != '0);
    assign send_pend    = pend_valid && have_credit;
    assign in_ret.stall = pend_valid && !send_pend;           // Record held
    assign accept       = in_ret.valid && !in_ret.stall;
    assign send_in      = accept && !pend_valid && have_credit;   // Fast path
    assign spend        = send_pend || send_in;

    //////////////////////////////////////////////////////////////////////////
    // Credits and control
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            credits    <= CRED_W'(RETIRE_CREDITS);
            pend_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            credits   <= credits - CRED_W'(spend) + CRED_W'(out_credit);
            out_valid <= spend;                  // One pulse per retirement
            if (accept && !send_in) begin
                pend_valid <= 1'b1;              // No credit, or pending leaving
            end else if (send_pend) begin
                pend_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !send_in) begin
            pend_rd      <= in_ret.rd;
            pend_value   <= in_ret.value;
            pend_illegal <= in_ret.illegal;
        end
        if (send_pend) begin
            out_rd      <= pend_rd;
            out_value   <= pend_value;
            out_illegal <= pend_illegal;
        end else if (send_in) begin
            out_rd      <= in_ret.rd;
            out_value   <= in_ret.value;
            out_illegal <= in_ret.illegal;
        end
    end

    // Consumer returned more credits than it was given
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credits <= CRED_W'(RETIRE_CREDITS));

endmodule

`default_nettype wire

/* source/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;                 // Data word or raw instruction
    typedef logic [4:0]  reg_idx_t;              // Register index x0..x31

    // Major opcodes, instruction bits 6 to 2
    typedef enum logic [4:0] {
        op_imm = 5'b00100,                       // OP-IMM
        op_reg = 5'b01100,                       // OP
        op_lui = 5'b01101                        // LUI
    } opcode_e;

    // ALU operation is funct7[5] followed by funct3
    typedef enum logic [3:0] {
        alu_add    = 4'b0000,
        alu_sll    = 4'b0001,
        alu_slt    = 4'b0010,
        alu_sltu   = 4'b0011,
        alu_xor    = 4'b0100,
        alu_srl    = 4'b0101,
        alu_or     = 4'b0110,
        alu_and    = 4'b0111,
        alu_sub    = 4'b1000,
        alu_sra    = 4'b1101,
        alu_pass_b = 4'b1111                     // Unused code point, LUI result
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////////
    // Field extraction
    //////////////////////////////////////////////////////////////////////////

    function automatic opcode_e get_opcode(word_t instr);
        return opcode_e'(instr[6:2]);            // Unknown codes kept as raw value
    endfunction

    function automatic reg_idx_t get_rd(word_t instr);
        return instr[11:7];
    endfunction

    function automatic reg_idx_t get_rs1(word_t instr);
        return instr[19:15];
    endfunction

    function automatic reg_idx_t get_rs2(word_t instr);
        return instr[24:20];
    endfunction

    function automatic logic [2:0] get_funct3(word_t instr);
        return instr[14:12];
    endfunction

    function automatic word_t imm_i(word_t instr);
        return {{20{instr[31]}}, instr[31:20]};  // Sign extended 12 bit
    endfunction

    function automatic word_t imm_u(word_t instr);
        return {instr[31:12], 12'b0};
    endfunction

endpackage

`default_nettype wire

/* sources.f */
source/rv_core_pkg.sv
source/pipe_if.sv
source/instr_queue.sv
source/reg_file.sv
source/id_stage.sv
source/alu_stage.sv
source/retire_port.sv
source/alu_core_top.sv
test/tb_alu_core.sv

/* test/tb_alu_core.sv */
`default_nettype none

module tb_alu_core import rv_core_pkg::*; #(
    parameter int QUEUE_DEPTH    = 4,
    parameter int RETIRE_CREDITS = 2
) ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RANDOM = 400;                 // Mixed random instructions
    localparam int NUM_CHAIN  = 60;                  // Dependent chain length
    localparam int NUM_INSTR  = 14 + NUM_RANDOM + 2 + NUM_CHAIN;
    localparam int MAX_CYCLES = 20 * NUM_INSTR + 200;

    logic     clk;
    logic     reset;
    logic     in_valid;
    word_t    in_instr;
    logic     in_credit;
    logic     out_valid;
    reg_idx_t out_rd;
    word_t    out_value;
    logic     out_illegal;
    logic     out_credit;

    word_t       lcg_state = 32'h35ce_d07d;
    word_t       model_regs [32];                    // Reference register file
    logic [37:0] exp_q [$];                          // {illegal, rd, value} in program order
    word_t       prog_q [$];
    int          prod_credits;
    int          cons_credits;                       // Consumer view of the DUT's credits
    int          owed;                               // Records not yet credited back
    int          hold;                               // Cycles before the next credit return
    int          sent;
    int          retired;
    int          credit_pulses;
    int          cycle_count = 0;

    alu_core_top #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .RETIRE_CREDITS (RETIRE_CREDITS)
    ) i_dut (
        .clk(clk), .reset(reset),
        .in_valid(in_valid), .in_instr(in_instr), .in_credit(in_credit),
        .out_valid(out_valid), .out_rd(out_rd), .out_value(out_value),
        .out_illegal(out_illegal), .out_credit(out_credit)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;                            // 8 ns period

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d retired", cycle_count, retired,
                     NUM_INSTR);
            $display("TESTBENCH FAILED");
            $fatal(1, "Simulation timed out");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus generation
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);        // Mix high bits down
    endfunction

    function automatic reg_idx_t pick_reg();
        word_t r;
        r = lcg_next();
        return (r[31:29] == 3'd0) ? r[4:0] : {2'b00, r[2:0]};   // Mostly x0..x7
    endfunction

    function automatic word_t enc_r(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                    logic [2:0] f3, logic alt);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_i(reg_idx_t rd, reg_idx_t rs1, logic [2:0] f3,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // One random instruction, ALU classes only for the chain
    function automatic word_t gen_instr(reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                                        logic alu_only);
        word_t      r;
        logic [2:0] f3;
        logic [3:0] cls;
        logic [4:0] bad_op;
        r   = lcg_next();
        f3  = r[14:12];
        cls = alu_only ? (r[0] ? 4'd0 : 4'd8) : r[3:0];
        if (cls < 4'd6) begin
            return enc_r(rd, rs1, rs2, f3, r[20] && (f3 == 3'd0 || f3 == 3'd5));
        end
        if (cls < 4'd12) begin
            case (f3)
                3'd1:    return enc_i(rd, rs1, f3, {7'd0, r[24:20]});
                3'd5:    return enc_i(rd, rs1, f3, {1'b0, r[30], 5'd0, r[24:20]});
                default: return enc_i(rd, rs1, f3, r[31:20]);
            endcase
        end
        if (cls < 4'd14) return enc_lui(rd, r[31:12]);
        case (r[6:4])                                // Opcodes the pipe does not run
            3'd0:    bad_op = 5'b00000;              // LOAD
            3'd1:    bad_op = 5'b01000;              // STORE
            3'd2:    bad_op = 5'b11000;              // BRANCH
            3'd3:    bad_op = 5'b11011;              // JAL
            3'd4:    bad_op = 5'b00101;              // AUIPC
            default: bad_op = 5'b11100;              // SYSTEM
        endcase
        return {r[31:12], rd, bad_op, 2'b11};
    endfunction

    task automatic build_program();
        reg_idx_t prev;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    r;
        for (int i = 1; i < 8; i++) begin            // Known operands in x1..x7
            r = lcg_next();
            prog_q.push_back(enc_lui(reg_idx_t'(i), r[31:12]));
            prog_q.push_back(enc_i(reg_idx_t'(i), reg_idx_t'(i), 3'd0, r[11:0]));
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rd  = pick_reg();
            rs1 = pick_reg();
            rs2 = pick_reg();
            prog_q.push_back(gen_instr(rd, rs1, rs2, 1'b0));
        end
        prog_q.push_back(enc_i(5'd0, 5'd1, 3'd0, 12'h005));      // Write to x0
        prog_q.push_back(enc_r(5'd3, 5'd0, 5'd0, 3'd0, 1'b0));   // Must read zero back
        prev = 5'd3;
        for (int i = 0; i < NUM_CHAIN; i++) begin    // Each reads the previous rd
            r   = lcg_next();
            rd  = (r[2:0] == 3'd0) ? 5'd1 : {2'b00, r[2:0]};
            rs2 = r[8] ? prev : pick_reg();
            prog_q.push_back(gen_instr(rd, prev, rs2, 1'b1));
            prev = rd;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic word_t ref_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic model_step(input word_t instr);
        reg_idx_t rd;
        word_t    a;
        word_t    value;
        logic     illegal;
        rd      = instr[11:7];
        a       = model_regs[instr[19:15]];
        value   = '0;
        illegal = 1'b0;
        case (instr[6:0])
            7'b0110011: value = ref_alu(instr[14:12], instr[30], a, model_regs[instr[24:20]]);
            7'b0010011: value = ref_alu(instr[14:12], instr[30] && (instr[14:12] == 3'd5), a,
                                        {{20{instr[31]}}, instr[31:20]});
            7'b0110111: value = {instr[31:12], 12'd0};
            default:    illegal = 1'b1;              // Zero value, no write
        endcase
        if (!illegal && rd != 5'd0) model_regs[rd] = value;
        exp_q.push_back({illegal, rd, value});
    endtask

    task automatic compare(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Producer and consumer, all on the falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic sample_outputs();
        logic [37:0] rec;
        if (in_credit) begin
            credit_pulses++;
            prod_credits++;
            compare("producer credits within QUEUE_DEPTH", 32'd1,
                    32'(prod_credits <= QUEUE_DEPTH));
        end
        if (out_valid && exp_q.size() == 0) begin
            $display("Retire record seen with no instruction outstanding");
            $display("TESTBENCH FAILED");
            $fatal(1, "Unexpected retirement");
        end else if (out_valid) begin
            rec = exp_q.pop_front();
            compare($sformatf("retire %0d rd", retired), 32'(rec[36:32]), 32'(out_rd));
            compare($sformatf("retire %0d value", retired), rec[31:0], out_value);
            compare($sformatf("retire %0d illegal", retired), 32'(rec[37]), 32'(out_illegal));
            retired++;
            owed++;
            cons_credits--;                          // Never more than granted
            compare("retire within granted credits", 32'd1, 32'(cons_credits >= 0));
        end
    endtask

    task automatic return_credit();
        word_t r;
        out_credit = 1'b0;
        if (hold > 0) begin
            hold--;
        end else if (owed > 0) begin
            out_credit = 1'b1;
            owed--;
            cons_credits++;
            r    = lcg_next();
            hold = (r[31:29] == 3'd0) ? int'(r[5:0]) : int'(r[1:0]);   // Long stall at times
        end
    endtask

    task automatic drive_input();
        word_t r;
        in_valid = 1'b0;
        r        = lcg_next();
        if (sent < prog_q.size() && prod_credits > 0 && r[31:30] != 2'b00) begin
            in_valid = 1'b1;
            in_instr = prog_q[sent];
            model_step(prog_q[sent]);
            sent++;
            prod_credits--;                          // One credit per send
        end
    endtask

    initial begin
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_instr      = '0;
        out_credit    = 1'b0;
        prod_credits  = QUEUE_DEPTH;
        cons_credits  = RETIRE_CREDITS;
        owed          = 0;
        hold          = 0;
        sent          = 0;
        retired       = 0;
        credit_pulses = 0;
        foreach (model_regs[i]) model_regs[i] = '0;
        build_program();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        while (retired < prog_q.size()) begin
            @(negedge clk);
            sample_outputs();
            return_credit();
            drive_input();
        end
        repeat (8) begin                             // Drain, nothing more may retire
            @(negedge clk);
            sample_outputs();
            return_credit();
        end
        compare("in_credit pulses vs sent", 32'(sent), 32'(credit_pulses));
        compare("producer credits after drain", 32'(QUEUE_DEPTH), 32'(prod_credits));
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
